//--- logic/uart_pkg.sv
//////////////////////////////////////////////////////////////////////
// UART shared constants, vector types and frame position encoding.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package uart_pkg;

	// Line timing.
	localparam logic [31:0] CLOCKRATE = 32'd50_000_000;
	localparam logic [31:0] BAUDRATE = 32'd3_125_000;
	localparam int BIT_INTERVAL = CLOCKRATE / BAUDRATE;
	localparam int SAMPLE_POINT = BIT_INTERVAL / 2;

	// Buffer geometry.
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_ADDR_W = 4;

	typedef logic [7:0] byte_t;
	typedef logic [2:0] bit_count_t;
	typedef logic [4:0] baud_count_t;

	// Extra bit tells full from empty.
	typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

	typedef enum logic [2:0] {
		LINE_IDLE,
		LINE_START,
		LINE_DATA,
		LINE_PARITY,
		LINE_STOP
	} line_state_t;

endpackage

`default_nettype wire

//--- logic/byte_fifo.sv
//////////////////////////////////////////////////////////////////////
// First-word-fall-through byte FIFO with empty and full flags.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import uart_pkg::*; (
	input wire logic CLK,
	input wire logic RST,

	input wire logic write_flag,
	input wire byte_t write_data,
	input wire logic read_flag,
	output byte_t read_data,

	output logic empty,
	output logic full
);

	byte_t mem [FIFO_DEPTH];
	fifo_ptr_t write_ptr;
	fifo_ptr_t read_ptr;
	logic do_write;
	logic do_read;

	assign do_write = write_flag && !full;
	assign do_read = read_flag && !empty;

	// Wrap bits tell full from empty when the slots match.
	assign empty = (write_ptr == read_ptr);
	assign full = (write_ptr[FIFO_ADDR_W] != read_ptr[FIFO_ADDR_W]) &&
		(write_ptr[FIFO_ADDR_W-1:0] == read_ptr[FIFO_ADDR_W-1:0]);

	assign read_data = mem[read_ptr[FIFO_ADDR_W-1:0]];

	always_ff @(posedge CLK) begin
		if (do_write) begin
			mem[write_ptr[FIFO_ADDR_W-1:0]] <= write_data;
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			write_ptr <= '0;
			read_ptr <= '0;
		end else begin
			if (do_write) begin
				write_ptr <= write_ptr + fifo_ptr_t'(1);
			end
			if (do_read) begin
				read_ptr <= read_ptr + fifo_ptr_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/uart_receiver.sv
//////////////////////////////////////////////////////////////////////
// UART receive engine with start detection, mid-bit sampling and parity check.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_receiver import uart_pkg::*; (
	input wire logic CLK,
	input wire logic RST,

	input wire logic rx,
	input wire logic fifo_full,

	output logic write_flag,
	output byte_t write_data
);

	line_state_t state;
	baud_count_t baud_count;
	bit_count_t bit_idx;
	logic parity;
	logic sample;

	assign sample = (baud_count == baud_count_t'(SAMPLE_POINT));

	// Counter held at zero while idle, so a start edge restarts it.
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			baud_count <= '0;
		end else if (state == LINE_IDLE) begin
			baud_count <= '0;
		end else if (baud_count == baud_count_t'(BIT_INTERVAL - 1)) begin
			baud_count <= '0;
		end else begin
			baud_count <= baud_count + baud_count_t'(1);
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= LINE_IDLE;
			bit_idx <= '0;
			parity <= 1'b0;
			write_flag <= 1'b0;
		end else begin
			write_flag <= 1'b0;
			case (state)
				LINE_IDLE: begin
					if (!rx) begin
						state <= LINE_START;
					end
				end
				LINE_START: begin
					if (sample) begin
						if (!rx) begin
							state <= LINE_DATA;
							bit_idx <= '0;
							parity <= 1'b0;
						end else begin
							// False start returns to idle.
							state <= LINE_IDLE;
						end
					end
				end
				LINE_DATA: begin
					if (sample) begin
						parity <= parity ^ rx;
						bit_idx <= bit_idx + bit_count_t'(1);
						if (bit_idx == 3'd7) begin
							state <= LINE_PARITY;
						end
					end
				end
				LINE_PARITY: begin
					if (sample) begin
						if (rx == parity && !fifo_full) begin
							write_flag <= 1'b1;
						end
						state <= LINE_STOP;
					end
				end
				LINE_STOP: begin
					// Stop bit value is not checked.
					if (sample) begin
						state <= LINE_IDLE;
					end
				end
				default: state <= LINE_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == LINE_DATA && sample) begin
			write_data[bit_idx] <= rx;
		end
	end

endmodule

`default_nettype wire

//--- logic/uart_transmitter.sv
//////////////////////////////////////////////////////////////////////
// UART transmit engine with bit pacing and a frame serializer.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter import uart_pkg::*; (
	input wire logic CLK,
	input wire logic RST,

	input wire logic fifo_empty,
	input wire byte_t fifo_data,
	output logic read_flag,

	output logic tx
);

	baud_count_t baud_count;
	line_state_t state;
	bit_count_t bit_idx;
	byte_t frame_data;
	logic bit_tick;
	logic load;

	assign bit_tick = (baud_count == '0);
	assign load = bit_tick && (state == LINE_IDLE) && !fifo_empty;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			baud_count <= '0;
		end else if (baud_count == baud_count_t'(BIT_INTERVAL - 1)) begin
			baud_count <= '0;
		end else begin
			baud_count <= baud_count + baud_count_t'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (load) begin
			frame_data <= fifo_data;
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= LINE_IDLE;
			bit_idx <= '0;
			read_flag <= 1'b0;
			tx <= 1'b1;
		end else begin
			read_flag <= 1'b0;
			if (bit_tick) begin
				case (state)
					LINE_IDLE: begin
						// Start bit goes out as the byte is taken.
						if (!fifo_empty) begin
							read_flag <= 1'b1;
							tx <= 1'b0;
							bit_idx <= '0;
							state <= LINE_DATA;
						end
					end
					LINE_DATA: begin
						tx <= frame_data[bit_idx];
						bit_idx <= bit_idx + bit_count_t'(1);
						if (bit_idx == 3'd7) begin
							state <= LINE_PARITY;
						end
					end
					LINE_PARITY: begin
						tx <= ^frame_data;
						state <= LINE_STOP;
					end
					LINE_STOP: begin
						tx <= 1'b1;
						state <= LINE_IDLE;
					end
					default: state <= LINE_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/uart.sv
//////////////////////////////////////////////////////////////////////
// UART top level with buffered transmit and receive paths.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart import uart_pkg::*; (
	input wire logic CLK,
	input wire logic RST,

	input wire logic send_flag,
	input wire byte_t send_data,
	input wire logic recv_flag,
	output byte_t recv_data,

	output logic sendable,
	output logic receivable,

	output logic tx,
	input wire logic rx
);

	logic send_read_flag;
	byte_t send_head;
	logic send_empty;
	logic send_full;

	logic recv_write_flag;
	byte_t recv_write_data;
	logic recv_empty;
	logic recv_full;

	assign sendable = !send_full;
	assign receivable = !recv_empty;

	byte_fifo send_buffer (
		.CLK(CLK),
		.RST(RST),
		.write_flag(send_flag),
		.write_data(send_data),
		.read_flag(send_read_flag),
		.read_data(send_head),
		.empty(send_empty),
		.full(send_full)
	);

	byte_fifo recv_buffer (
		.CLK(CLK),
		.RST(RST),
		.write_flag(recv_write_flag),
		.write_data(recv_write_data),
		.read_flag(recv_flag),
		.read_data(recv_data),
		.empty(recv_empty),
		.full(recv_full)
	);

	uart_receiver receiver_i (
		.CLK(CLK),
		.RST(RST),
		.rx(rx),
		.fifo_full(recv_full),
		.write_flag(recv_write_flag),
		.write_data(recv_write_data)
	);

	uart_transmitter transmitter_i (
		.CLK(CLK),
		.RST(RST),
		.fifo_empty(send_empty),
		.fifo_data(send_head),
		.read_flag(send_read_flag),
		.tx(tx)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock with a 10 ns period and power-on reset.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Reset held for three rising edges.
	initial begin
		RST = 1'b1;
		repeat (3) @(posedge CLK);
		#1;
		RST = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/uart_tb.sv
//////////////////////////////////////////////////////////////////////
// UART testbench with a serial line driver, frame decoder and scoreboard.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

	localparam int FRAME_CYCLES = 11 * BIT_INTERVAL;
	localparam int BYTE_TIMEOUT = 3 * FRAME_CYCLES;
	localparam int WATCHDOG_CYCLES = 60 * FRAME_CYCLES + 1000;

	logic CLK;
	logic RST;
	logic send_flag;
	byte_t send_data;
	logic recv_flag;
	byte_t recv_data;
	logic sendable;
	logic receivable;
	logic tx;
	logic rx;
	logic loopback;
	logic line_drv;

	integer seed;
	int checks;
	int errors;
	int tests_run;
	int tests_failed;
	int errors_before;
	string test_name;
	byte_t pending_q[$];
	byte_t expected_q[$];

	// Receiver listens to its own transmitter or to the line driver.
	assign rx = loopback ? tx : line_drv;

	tb_clock_gen clock_gen_i (
		.CLK(CLK),
		.RST(RST)
	);

	uart uart_i (
		.CLK(CLK), .RST(RST),
		.send_flag(send_flag), .send_data(send_data),
		.recv_flag(recv_flag), .recv_data(recv_data),
		.sendable(sendable), .receivable(receivable),
		.tx(tx), .rx(rx)
	);

	// Even parity over the data bits.
	function automatic logic even_parity(input byte_t value);
		logic p;
		byte_t rest;
		p = 1'b0;
		rest = value;
		repeat (8) begin
			p = p ^ rest[0];
			rest = rest >> 1;
		end
		return p;
	endfunction

	task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s is %02h, expected %02h",
				$time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b",
				$time, name, actual, expected);
		end
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b",
				$time, name, actual, expected);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_before = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAIL, %0d errors", tests_run, test_name,
				errors - errors_before);
		end
	endtask

	task automatic queue_random(input int count);
		byte_t value;
		repeat (count) begin
			value = byte_t'($random(seed));
			pending_q.push_back(value);
			expected_q.push_back(value);
		end
	endtask

	task automatic push_pending();
		while (pending_q.size() > 0) begin
			@(posedge CLK);
			#1;
			send_flag = 1'b1;
			send_data = pending_q.pop_front();
			@(posedge CLK);
			#1;
			send_flag = 1'b0;
		end
	endtask

	// Decodes one tx frame of start, eight data bits LSB first and parity.
	task automatic decode_frame(output byte_t data, output logic parity);
		data = '0;
		@(negedge tx);
		repeat (SAMPLE_POINT) @(posedge CLK);
		#1;
		check_bit("tx start bit", tx, 1'b0);
		repeat (8) begin
			repeat (BIT_INTERVAL) @(posedge CLK);
			#1;
			data = {tx, data[7:1]};
		end
		repeat (BIT_INTERVAL) @(posedge CLK);
		#1;
		parity = tx;
	endtask

	task automatic decode_expected(input int count);
		byte_t data;
		byte_t expected;
		logic parity;
		repeat (count) begin
			decode_frame(data, parity);
			expected = expected_q.pop_front();
			check_byte("tx data", data, expected);
			check_bit("tx parity", parity, even_parity(expected));
		end
	endtask

	task automatic send_frame(input byte_t value, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, even_parity(value) ^ bad_parity, value, 1'b0};
		@(posedge CLK);
		#1;
		repeat (11) begin
			line_drv = frame[0];
			frame = frame >> 1;
			repeat (BIT_INTERVAL) @(posedge CLK);
			#1;
		end
	endtask

	task automatic wait_receivable();
		int waited;
		waited = 0;
		while (!receivable && waited < BYTE_TIMEOUT) begin
			@(posedge CLK);
			#1;
			waited++;
		end
		if (!receivable) begin
			errors++;
			$display("Timeout at %0t: no byte arrived in the receive FIFO", $time);
		end
	endtask

	task automatic pop_and_check();
		byte_t expected;
		wait_receivable();
		expected = expected_q.pop_front();
		check_byte("recv_data", recv_data, expected);
		recv_flag = 1'b1;
		@(posedge CLK);
		#1;
		recv_flag = 1'b0;
	endtask

	task automatic settle_line();
		repeat (2 * BIT_INTERVAL) @(posedge CLK);
		#1;
	endtask

	initial begin
		byte_t value;
		int k;
		seed = 32'h9118_5b61;
		send_flag = 1'b0;
		send_data = '0;
		recv_flag = 1'b0;
		line_drv = 1'b1;
		loopback = 1'b0;
		@(negedge RST);
		@(posedge CLK);
		#1;

		start_test("reset state");
		check_level("tx", tx, 1'b1);
		check_level("sendable", sendable, 1'b1);
		check_level("receivable", receivable, 1'b0);
		finish_test();

		start_test("transmit framing");
		queue_random(4);
		fork
			push_pending();
			decode_expected(4);
		join
		settle_line();
		finish_test();

		start_test("loopback");
		loopback = 1'b1;
		queue_random(8);
		push_pending();
		repeat (8) pop_and_check();
		settle_line();
		loopback = 1'b0;
		finish_test();

		start_test("parity rejection");
		send_frame(byte_t'($random(seed)), 1'b1);
		check_level("receivable after bad parity", receivable, 1'b0);
		value = byte_t'($random(seed));
		expected_q.push_back(value);
		send_frame(value, 1'b0);
		pop_and_check();
		check_level("receivable after one pop", receivable, 1'b0);
		finish_test();

		start_test("receive overflow");
		for (k = 0; k < FIFO_DEPTH + 1; k++) begin
			value = byte_t'($random(seed));
			if (k < FIFO_DEPTH) begin
				expected_q.push_back(value);
			end
			send_frame(value, 1'b0);
		end
		check_level("receivable when full", receivable, 1'b1);
		repeat (FIFO_DEPTH) pop_and_check();
		check_level("receivable after draining", receivable, 1'b0);
		finish_test();

		start_test("false start");
		line_drv = 1'b0;
		repeat (SAMPLE_POINT / 2) @(posedge CLK);
		#1;
		line_drv = 1'b1;
		settle_line();
		value = byte_t'($random(seed));
		expected_q.push_back(value);
		send_frame(value, 1'b0);
		pop_and_check();
		check_level("receivable after one pop", receivable, 1'b0);
		finish_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout at %0t: watchdog expired before the tests finished", $time);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
logic/uart_pkg.sv
logic/byte_fifo.sv
logic/uart_receiver.sv
logic/uart_transmitter.sv
logic/uart.sv
tests/tb_clock_gen.sv
tests/uart_tb.sv

//--- Makefile
SIM := obj_dir/Vuart_tb
SOURCES := $(wildcard logic/*.sv tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): flist.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module uart_tb -f flist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -qF '*** FAILED ***' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
